// File: shufflev.f
source/shufflev_pkg.sv
source/shufflev_decoder.sv
source/shufflev_rename.sv
source/shufflev_entries.sv
source/shufflev_lfsr.sv
source/shufflev_picker.sv
source/shufflev_fetch_gate.sv
source/shufflev_buffer.sv
testbench/tb_shufflev.sv

// File: Bender.yml
package:
  name: shufflev

sources:
  - source/shufflev_pkg.sv
  - source/shufflev_decoder.sv
  - source/shufflev_rename.sv
  - source/shufflev_entries.sv
  - source/shufflev_lfsr.sv
  - source/shufflev_picker.sv
  - source/shufflev_fetch_gate.sv
  - source/shufflev_buffer.sv
  - target: test
    files:
      - testbench/tb_shufflev.sv

// File: testbench/tb_shufflev.sv
`timescale 1ns/1ns

module tb_shufflev import shufflev_pkg::*;;

  localparam int NumBlocks = 7;                            // six before the flush and one after
  localparam int BlockLen  = 7;                            // plain instructions ahead of each branch
  localparam int FlushLen  = 4;                            // fills the buffer so the flush clears it
  localparam int NumInstr  = NumBlocks * (BlockLen + 1) + FlushLen;
  localparam int Limit     = 40 * NumInstr;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] addr;
    int          seq;  // program order
    int          w1;   // latest older writer of rs1, -1 when there is none or rs1 is not read
    int          w2;
  } rec_t;

  logic clk_i, rst_ni, fetch_valid_i, fetch_ready_o, valid_o, ready_i, branch_i, flush_i;
  logic [31:0] fetch_instr_i, fetch_addr_i;
  issue_t      issue_o;

  int          seed = 92;
  int          cycles = 0;
  int          n_acc = 0;
  int          last_writer [32];
  logic [5:0]  rd_rep [NumInstr];   // rd_phys each instruction reported when it issued
  rec_t        pending [$];         // accepted and not yet issued, oldest first
  logic [31:0] next_addr = 32'h0000_1000;
  bit          waiting = 0;         // fetch must stay shut until the core rules on the branch
  bit          br_issued_prev = 0;

  shufflev_buffer #(.BuffSize(4)) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  function automatic bit writes_rd(logic [31:0] ins);
    return !(ins[6:0] inside {BRANCH, STORE}) && ins[11:7] != 5'd0;  // x0 keeps physical 0
  endfunction
  function automatic bit reads_rs1(logic [31:0] ins);
    return ins[6:0] != LUI;  // every generated form except lui reads rs1
  endfunction
  function automatic bit reads_rs2(logic [31:0] ins);
    return ins[6:0] inside {OP, STORE, BRANCH};
  endfunction
  function automatic bit is_mem(logic [31:0] ins);
    return ins[6:0] inside {LOAD, STORE};
  endfunction
  function automatic bit is_sys(logic [31:0] ins);
    return ins[6:0] == SYSTEM;
  endfunction

  // an instruction may leave only when no older pending one feeds it, shares memory or fences it
  function automatic bit is_allowed(rec_t r);
    foreach (pending[i]) begin
      if (pending[i].seq < r.seq) begin
        if (pending[i].seq == r.w1 || pending[i].seq == r.w2) return 1'b0;
        if (is_mem(pending[i].instr) && is_mem(r.instr)) return 1'b0;
        if (is_sys(pending[i].instr) || is_sys(r.instr)) return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // a source names its writer's physical register, or the identity mapping from reset
  function automatic logic [5:0] expected_src(bit used, int w, logic [4:0] lidx);
    if (!used) return 6'd0;
    if (w < 0) return {1'b0, lidx};
    return rd_rep[w];
  endfunction

  // small register range so that chains of dependencies show up often
  function automatic logic [31:0] gen_plain();
    logic [4:0] rd, rs1, rs2;
    rd  = 5'($random(seed) & 7);
    rs1 = 5'($random(seed) & 7);
    rs2 = 5'($random(seed) & 7);
    case ({$random(seed)} % 6)
      0:       return {7'h00, rs2, rs1, 3'b000, rd, OP};
      1:       return {12'h005, rs1, 3'b000, rd, OP_IMM};
      2:       return {20'h12345, rd, LUI};
      3:       return {12'h010, rs1, 3'b010, rd, LOAD};
      4:       return {7'h00, rs2, rs1, 3'b010, 5'h04, STORE};
      default: return {12'h340, rs1, 3'b001, rd, SYSTEM};  // csrrw, a barrier that writes rd
    endcase
  endfunction

  task automatic send_instr(input logic [31:0] instr);
    @(negedge clk_i);
    fetch_valid_i = 1'b1;
    fetch_instr_i = instr;
    fetch_addr_i  = next_addr;
    do @(posedge clk_i); while (!fetch_ready_o);  // held until the buffer takes it
    next_addr += 4;
  endtask

  task automatic run_block(input bit redirect);
    logic [31:0] br_addr;
    for (int i = 0; i < BlockLen; i++) send_instr(gen_plain());
    br_addr = next_addr;
    send_instr({7'h00, 5'($random(seed) & 7), 5'($random(seed) & 7), 3'b000, 5'h08, BRANCH});
    if (redirect) begin
      @(negedge clk_i);
      fetch_valid_i = 1'b0;
      do @(posedge clk_i); while (!(valid_o && ready_i && issue_o.addr == br_addr));
      @(negedge clk_i);
      ready_i = 1'b0;  // no fall-through, the gate keeps waiting for the redirect
      @(negedge clk_i);
      ready_i = 1'b1;
      while (pending.size() != 0) @(negedge clk_i);  // drains while fetch is held
      branch_i = 1'b1;
      @(negedge clk_i);
      branch_i = 1'b0;
      @(posedge clk_i);
      compare("fetch_ready_o", fetch_ready_o, 1);
      compare("valid_o", valid_o, 0);
    end
  endtask

  task automatic take_issue();
    rec_t r;
    int   k;
    k = -1;
    foreach (pending[i]) begin
      if (pending[i].addr == issue_o.addr) k = i;
    end
    if (k < 0) abort_run($sformatf("issue at %h was never accepted or was flushed", issue_o.addr));
    r = pending[k];
    compare("issue_o.instr", issue_o.instr, r.instr);
    if (!is_allowed(r)) abort_run($sformatf("instruction at %h overtook one it depends on", r.addr));
    if (!writes_rd(r.instr)) compare("issue_o.rd_phys", issue_o.rd_phys, 0);
    else if (issue_o.rd_phys == 6'd0) abort_run($sformatf("no register renamed at %h", r.addr));
    rd_rep[r.seq] = issue_o.rd_phys;
    compare("issue_o.rs1_phys", issue_o.rs1_phys,
            expected_src(reads_rs1(r.instr), r.w1, r.instr[19:15]));
    compare("issue_o.rs2_phys", issue_o.rs2_phys,
            expected_src(reads_rs2(r.instr), r.w2, r.instr[24:20]));
    if (r.instr[6:0] == BRANCH) br_issued_prev = 1'b1;  // fall-through may reopen fetch next cycle
    pending.delete(k);
  endtask

  task automatic record_accept();
    rec_t r;
    r.instr = fetch_instr_i;
    r.addr  = fetch_addr_i;
    r.seq   = n_acc++;
    r.w1    = reads_rs1(fetch_instr_i) ? last_writer[fetch_instr_i[19:15]] : -1;
    r.w2    = reads_rs2(fetch_instr_i) ? last_writer[fetch_instr_i[24:20]] : -1;
    if (writes_rd(fetch_instr_i)) last_writer[fetch_instr_i[11:7]] = r.seq;
    if (fetch_instr_i[6:0] == BRANCH) waiting = 1'b1;
    pending.push_back(r);
  endtask

  // outputs are read at the rising edge, before any flop of the DUT moves
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (waiting && br_issued_prev && ready_i) begin
        compare("fetch_ready_o", fetch_ready_o, 1);  // not taken, fetch opens in this cycle
        waiting = 1'b0;
      end else if (waiting) begin
        compare("fetch_ready_o", fetch_ready_o, 0);
        compare("valid_o", valid_o, !branch_i && pending.size() != 0);  // drains a partly full buffer
        if (branch_i) waiting = 1'b0;  // redirect opens fetch from the next cycle on
      end
      br_issued_prev = 1'b0;
      if (valid_o && ready_i) take_issue();
      if (flush_i) pending.delete();
      if (fetch_valid_i && fetch_ready_o) record_accept();
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > Limit) abort_run($sformatf("timeout, run still busy after %0d cycles", cycles));
  end

  initial begin
    foreach (last_writer[i]) last_writer[i] = -1;
    rst_ni        = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = 32'h0000_0013;  // nop keeps the decoder fed with a legal word
    fetch_addr_i  = '0;
    ready_i       = 1'b1;
    branch_i      = 1'b0;
    flush_i       = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    compare("valid_o", valid_o, 0);
    compare("fetch_ready_o", fetch_ready_o, 1);
    for (int b = 0; b < NumBlocks - 1; b++) run_block(b % 2);  // odd blocks end on a redirect
    @(negedge clk_i);
    ready_i = 1'b0;  // back-pressure keeps the stores in the buffer up to the flush
    for (int i = 0; i < FlushLen; i++) begin
      send_instr({7'h00, 5'($random(seed) & 7), 5'($random(seed) & 7), 3'b010, 5'h0, STORE});
    end
    @(negedge clk_i);
    fetch_valid_i = 1'b0;
    flush_i       = 1'b1;  // the stores write no rd so renaming is unaffected
    @(posedge clk_i);
    compare("valid_o", valid_o, 1);  // full and held by ready_i
    compare("fetch_ready_o", fetch_ready_o, 0);
    @(negedge clk_i);
    flush_i = 1'b0;
    ready_i = 1'b1;
    @(posedge clk_i);
    compare("valid_o", valid_o, 0);
    run_block(1);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: source/shufflev_buffer.sv
`timescale 1ns/1ns

module shufflev_buffer import shufflev_pkg::*; #(
  parameter int unsigned BuffSize = 4,
  parameter int unsigned RngSeed  = 32'h0000_ace1
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        fetch_valid_i,
  input  logic [31:0] fetch_instr_i,
  input  logic [31:0] fetch_addr_i,
  output logic        fetch_ready_o,
  output logic        valid_o,
  output issue_t      issue_o,
  input  logic        ready_i,
  input  logic        branch_i,
  input  logic        flush_i
);

  localparam int unsigned IdxW = $clog2(BuffSize);

  decoded_t               dec;
  phys_idx_t              rd_phys, rs1_phys, rs2_phys;
  issue_t                 new_entry;
  logic [BuffSize-1:0]    valid_vec, ready_vec;
  logic [NumPhysRegs-1:0] in_use;
  logic [IdxW-1:0]        pos, remove_idx;
  logic                   accept, issue, full, empty, paused;

  assign full  = &valid_vec;
  assign empty = ~|valid_vec;
  assign issue  = valid_o && ready_i;
  assign accept = fetch_valid_i && fetch_ready_o;

  // a full buffer still takes a new word when one entry leaves in the same cycle
  assign fetch_ready_o = !branch_i && !paused && (!full || issue);
  // hold issue until full to keep the shuffle wide, except while fetch waits on a branch
  assign valid_o = !branch_i && (full || (!empty && paused));

  assign new_entry = '{instr: fetch_instr_i, addr: fetch_addr_i,
                       rd_phys: rd_phys, rs1_phys: rs1_phys, rs2_phys: rs2_phys};

  shufflev_decoder u_decoder (.instr_i(fetch_instr_i), .dec_o(dec));

  shufflev_rename u_rename (
    .clk_i, .rst_ni,
    .insert_i   (accept),
    .dec_i      (dec),
    .in_use_i   (in_use),
    .rd_phys_o  (rd_phys),
    .rs1_phys_o (rs1_phys),
    .rs2_phys_o (rs2_phys)
  );

  shufflev_entries #(.BuffSize(BuffSize)) u_entries (
    .clk_i, .rst_ni,
    .insert_i (accept), .remove_i (issue), .flush_i (flush_i),
    .remove_idx_i (remove_idx),
    .dec_i    (dec),
    .entry_i  (new_entry),
    .valid_o  (valid_vec),
    .ready_o  (ready_vec),
    .in_use_o (in_use),
    .issue_o  (issue_o)
  );

  shufflev_lfsr #(.BuffSize(BuffSize), .RngSeed(RngSeed)) u_lfsr (.clk_i, .rst_ni, .pos_o(pos));

  shufflev_picker #(.BuffSize(BuffSize)) u_picker (
    .ready_i (ready_vec), .pos_i (pos), .remove_idx_o (remove_idx)
  );

  shufflev_fetch_gate u_fetch_gate (
    .clk_i, .rst_ni,
    .accept_i (accept), .may_change_pc_i (dec.may_change_pc), .accept_addr_i (fetch_addr_i),
    .issued_i (issue), .issued_addr_i (issue_o.addr),
    .ready_i, .branch_i,
    .paused_o (paused)
  );

  // the oldest buffered entry never waits, so offering an instruction means one is ready
  assert property (@(posedge clk_i) disable iff (!rst_ni) valid_o |-> ready_vec[remove_idx])
    else $error("issue offered from entry %0d that still has dependencies", remove_idx);

endmodule

// File: source/shufflev_fetch_gate.sv
`timescale 1ns/1ns

module shufflev_fetch_gate import shufflev_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        accept_i,         // an instruction enters the buffer this cycle
  input  logic        may_change_pc_i,  // and it is a control transfer
  input  logic [31:0] accept_addr_i,
  input  logic        issued_i,         // an instruction goes to the core this cycle
  input  logic [31:0] issued_addr_i,
  input  logic        ready_i,
  input  logic        branch_i,         // core redirected its pc
  output logic        paused_o
);

  gate_state_e state_q, state_d;
  logic [31:0] branch_addr_q;  // address of the transfer we are waiting on
  logic        just_issued_q;  // that transfer went to the core at the previous edge
  logic        not_taken;

  // the core drops ready_i the cycle after a taken transfer, so ready here means fall-through
  assign not_taken = just_issued_q && ready_i;

  always_comb begin
    state_d = state_q;
    if (state_q == GATE_WAIT && (branch_i || not_taken)) state_d = GATE_OPEN;
    if (accept_i && may_change_pc_i) state_d = GATE_WAIT;  // a new transfer beats the release
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= GATE_OPEN;
      just_issued_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      just_issued_q <= issued_i && (state_q == GATE_WAIT) && (issued_addr_i == branch_addr_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_i && may_change_pc_i) branch_addr_q <= accept_addr_i;
  end

  assign paused_o = (state_q == GATE_WAIT) && !not_taken;  // fall-through reopens fetch at once

endmodule

// File: source/shufflev_picker.sv
`timescale 1ns/1ns

module shufflev_picker #(
  parameter int unsigned BuffSize = 4
) (
  input  logic [BuffSize-1:0]         ready_i,
  input  logic [$clog2(BuffSize)-1:0] pos_i,
  output logic [$clog2(BuffSize)-1:0] remove_idx_o
);

  localparam int unsigned IdxW = $clog2(BuffSize);

  // row r of column c is the slot at signed distance 0, +1, -1, +2, -2 ... from c
  function automatic int unsigned dist_entry(int unsigned r, int unsigned c);
    int unsigned step;
    step = (r + 1) / 2;
    if (r == 0) begin
      return c;
    end else if (r % 2 == 1) begin
      return (c + step) % BuffSize;
    end
    return (c + BuffSize - step) % BuffSize;
  endfunction

  logic [BuffSize-1:0][BuffSize-1:0][IdxW-1:0] dist_tbl;  // [row][column]

  for (genvar r = 0; r < BuffSize; r++) begin : g_row
    for (genvar c = 0; c < BuffSize; c++) begin : g_col
      assign dist_tbl[r][c] = IdxW'(dist_entry(r, c));  // constant, folds away at elaboration
    end
  end

  // walk the chosen column from the far end so the nearest ready slot is the one left standing
  always_comb begin
    remove_idx_o = pos_i;  // nothing ready, valid_o is low anyway
    for (int r = BuffSize - 1; r >= 0; r--) begin
      if (ready_i[dist_tbl[r][pos_i]]) begin
        remove_idx_o = dist_tbl[r][pos_i];
      end
    end
  end

endmodule

// File: source/shufflev_lfsr.sv
`timescale 1ns/1ns

module shufflev_lfsr #(
  parameter int unsigned BuffSize = 4,
  parameter int unsigned RngSeed  = 32'h0000_ace1  // must be nonzero in its low 16 bits
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  output logic [$clog2(BuffSize)-1:0] pos_o   // random start position in the buffer
);

  localparam int unsigned IdxW = $clog2(BuffSize);
  localparam logic [15:0] Taps = 16'hb400;  // x^16 + x^14 + x^13 + x^11 + 1, maximal length

  logic [15:0] lfsr_q;

  // galois form: shift right and fold the tap mask in whenever a one drops out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 16'(RngSeed);
    end else begin
      lfsr_q <= {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? Taps : 16'h0000);
    end
  end

  assign pos_o = lfsr_q[IdxW-1:0];  // buffer size is a power of two so the low bits cover it

endmodule

// File: source/shufflev_entries.sv
`timescale 1ns/1ns

module shufflev_entries import shufflev_pkg::*; #(
  parameter int unsigned BuffSize = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        insert_i,
  input  logic                        remove_i,
  input  logic                        flush_i,
  input  logic [$clog2(BuffSize)-1:0] remove_idx_i,
  input  decoded_t                    dec_i,
  input  issue_t                      entry_i,      // instruction, address and renamed registers
  output logic [BuffSize-1:0]         valid_o,
  output logic [BuffSize-1:0]         ready_o,      // valid and waiting on nobody
  output logic [NumPhysRegs-1:0]      in_use_o,
  output issue_t                      issue_o
);

  localparam int unsigned IdxW = $clog2(BuffSize);

  issue_t [BuffSize-1:0]                   data_q;
  logic   [BuffSize-1:0]                   valid_q;
  logic   [BuffSize-1:0]                   mem_q;
  logic   [BuffSize-1:0]                   sys_q;
  logic   [BuffSize-1:0][BuffSize-1:0]     dep_q;    // row i lists the entries that i waits for
  logic   [BuffSize-1:0][NumPhysRegs-1:0]  usage_q;  // one-hot union of rd/rs1/rs2 per entry
  logic   [IdxW-1:0]                       insert_idx;
  logic   [BuffSize-1:0]                   new_dep;
  logic   [NumPhysRegs-1:0]                new_usage;

  always_comb begin
    insert_idx = '0;
    for (int i = BuffSize - 1; i >= 0; i--) begin
      if (!valid_q[i]) insert_idx = IdxW'(i);
    end
    // the slot being vacated this cycle is reused straight away, which also covers a full buffer
    if (remove_i) insert_idx = remove_idx_i;
  end

  always_comb begin
    for (int i = 0; i < BuffSize; i++) begin
      new_dep[i] = valid_q[i]
                && (((data_q[i].rd_phys != '0)
                     && (data_q[i].rd_phys == entry_i.rs1_phys
                         || data_q[i].rd_phys == entry_i.rs2_phys))
                    || (mem_q[i] && dec_i.is_mem)   // memory accesses stay in order
                    || sys_q[i] || dec_i.is_sys);   // barrier both ways
    end
    new_dep[insert_idx] = 1'b0;  // the old occupant of a reused slot is leaving this edge
  end

  assign new_usage = (NumPhysRegs'(1) << entry_i.rd_phys)
                   | (NumPhysRegs'(1) << entry_i.rs1_phys)
                   | (NumPhysRegs'(1) << entry_i.rs2_phys);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      usage_q <= '0;
      dep_q   <= '0;
    end else if (flush_i) begin
      valid_q <= '0;  // an insert in the same cycle is flushed along with the rest
      usage_q <= '0;
      dep_q   <= '0;
    end else begin
      if (remove_i) begin
        valid_q[remove_idx_i] <= 1'b0;
        usage_q[remove_idx_i] <= '0;
        for (int i = 0; i < BuffSize; i++) begin
          dep_q[i][remove_idx_i] <= 1'b0;  // wake up everyone waiting for it
        end
      end
      if (insert_i) begin
        valid_q[insert_idx] <= 1'b1;  // placed after the removal so a reused slot ends up valid
        usage_q[insert_idx] <= new_usage;
        dep_q[insert_idx]   <= new_dep;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (insert_i) begin
      data_q[insert_idx] <= entry_i;
      mem_q[insert_idx]  <= dec_i.is_mem;
      sys_q[insert_idx]  <= dec_i.is_sys;
    end
  end

  always_comb begin
    in_use_o = '0;
    for (int i = 0; i < BuffSize; i++) begin
      in_use_o |= usage_q[i];           // cleared slots contribute nothing
      ready_o[i] = valid_q[i] && !(|dep_q[i]);
    end
  end

  assign valid_o = valid_q;
  assign issue_o = data_q[remove_idx_i];

  // fetch_ready_o upstream has to hold back a full buffer unless an entry is leaving
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (insert_i && !remove_i) |-> !(&valid_q))
    else $error("insert into a full buffer");

endmodule

// File: source/shufflev_rename.sv
`timescale 1ns/1ns

module shufflev_rename import shufflev_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   insert_i,
  input  decoded_t               dec_i,
  input  logic [NumPhysRegs-1:0] in_use_i,   // registers still named by buffered entries
  output phys_idx_t              rd_phys_o,
  output phys_idx_t              rs1_phys_o,
  output phys_idx_t              rs2_phys_o
);

  phys_idx_t [NumLogicalRegs-1:0] map_q;       // logical to physical, binary form
  logic      [NumPhysRegs-1:0]    reserved_q;  // same mapping as a bit vector
  logic      [NumPhysRegs-1:0]    busy;
  phys_idx_t                      free_reg;
  logic                           free_found;
  logic                           writes_rd;
  logic                           alloc;

  // a register is only reusable once no mapping and no buffered entry refers to it
  assign busy = reserved_q | in_use_i;

  always_comb begin
    free_reg   = '0;
    free_found = 1'b0;
    for (int i = NumPhysRegs - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_reg   = phys_idx_t'(i);  // lowest free index wins
        free_found = 1'b1;
      end
    end
  end

  assign writes_rd = dec_i.has_rd && (dec_i.rd != '0);  // x0 is never renamed
  assign alloc     = insert_i && writes_rd;

  assign rd_phys_o  = writes_rd ? free_reg : '0;
  assign rs1_phys_o = dec_i.has_rs1 ? map_q[dec_i.rs1] : '0;  // read before this insert's update
  assign rs2_phys_o = dec_i.has_rs2 ? map_q[dec_i.rs2] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumLogicalRegs; i++) begin
        map_q[i] <= phys_idx_t'(i);
      end
      reserved_q <= {{(NumPhysRegs - NumLogicalRegs){1'b0}}, {NumLogicalRegs{1'b1}}};
    end else if (alloc) begin
      reserved_q[map_q[dec_i.rd]] <= 1'b0;  // old name is released
      reserved_q[free_reg]        <= 1'b1;  // free_reg is never the old name, so no clash
      map_q[dec_i.rd]             <= free_reg;
    end
  end

  // 32 mappings plus three names per buffered entry must always leave one register spare
  assert property (@(posedge clk_i) disable iff (!rst_ni) alloc |-> free_found)
    else $error("no free physical register for rd x%0d", dec_i.rd);

endmodule

// File: source/shufflev_decoder.sv
`timescale 1ns/1ns

module shufflev_decoder import shufflev_pkg::*; (
  input  logic [31:0] instr_i,
  output decoded_t    dec_o
);

  opcode_e    opcode;
  logic [2:0] funct3;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];

  always_comb begin
    dec_o.rd  = instr_i[11:7];
    dec_o.rs1 = instr_i[19:15];
    dec_o.rs2 = instr_i[24:20];

    // jumps, branches, fence and the privileged system forms (ecall/ebreak and xret)
    dec_o.may_change_pc = (opcode inside {JAL, JALR, BRANCH, MISC_MEM})
                       || (opcode == SYSTEM && funct3 == 3'b000
                           && instr_i[22:21] inside {2'b00, 2'b01});
    dec_o.is_mem = opcode inside {LOAD, STORE};
    // fence is grouped with the system instructions so it orders everything around it
    dec_o.is_sys = opcode inside {SYSTEM, MISC_MEM};

    dec_o.has_rd  = !((opcode inside {BRANCH, STORE, MISC_MEM})
                      || (opcode == SYSTEM && funct3 == 3'b000));
    dec_o.has_rs1 = !((opcode inside {LUI, AUIPC, JAL, MISC_MEM})
                      || (opcode == SYSTEM && funct3 inside {3'b000, 3'b101, 3'b110, 3'b111}));
    dec_o.has_rs2 = opcode inside {BRANCH, STORE, OP};  // b-, s- and r-type only
  end

  // the fetch bus only ever carries uncompressed encodings, idle cycles included
  always_comb begin
    if (!$isunknown(instr_i)) begin
      assert (instr_i[1:0] == 2'b11)
        else $error("compressed encoding %h reached the decoder", instr_i);
    end
  end

endmodule

// File: source/shufflev_pkg.sv
package shufflev_pkg;

  localparam int unsigned NumLogicalRegs = 32;  // rv32 architectural registers
  localparam int unsigned NumPhysRegs    = 64;  // 0..31 start out as the identity mapping

  typedef logic [4:0] log_idx_t;
  typedef logic [5:0] phys_idx_t;

  // major opcodes of the uncompressed rv32 encodings the buffer understands
  typedef enum logic [6:0] {
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011,
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    OP_IMM   = 7'b0010011,
    OP       = 7'b0110011,
    MISC_MEM = 7'b0001111,  // fence
    SYSTEM   = 7'b1110011   // ecall, ebreak, xret, wfi and csr forms
  } opcode_e;

  typedef struct packed {
    logic     may_change_pc;  // fetch has to wait for the core's verdict
    logic     is_mem;         // loads and stores keep their relative order
    logic     is_sys;         // acts as a barrier in both directions
    logic     has_rd;
    logic     has_rs1;
    logic     has_rs2;
    log_idx_t rd;
    log_idx_t rs1;
    log_idx_t rs2;
  } decoded_t;

  // what the core receives for every issued instruction
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] addr;
    phys_idx_t   rd_phys;   // 0 when the instruction writes nothing
    phys_idx_t   rs1_phys;  // 0 when rs1 is not read
    phys_idx_t   rs2_phys;  // 0 when rs2 is not read
  } issue_t;

  typedef enum logic {GATE_OPEN, GATE_WAIT} gate_state_e;

endpackage
